// ==== cpu_trace.txt ====
# T name | I addr w0 w1 w2 w3 (four words from addr) | R reg value | P halt pc
# Numbers in hex, P closes a test and runs it
T alu
I 00 A105 A2FD A37F A480
I 04 0512 1621 2734 0013
I 08 0801 F000 E000 E000
R 0 0000
R 2 FFFD
R 4 FF80
R 5 0002
R 6 FFF8
R 7 FFFF
R 8 0005
P 000A
T mem
I 00 A10A A2C3 9213 A35A
I 04 931E 8413 851E 9517
I 08 8617 0764 970F 880F
I 0C F000 E000 E000 E000
R 4 FFC3
R 5 005A
R 6 005A
R 7 001D
R 8 001D
P 000D
T zflag
I 00 A101 1311 C201 A401
I 04 C001 A501 0611 C201
I 08 A701 C001 A801 CE01
I 0C A901 F000 E000 E000
R 3 0000
R 4 0000
R 5 0001
R 6 0002
R 7 0001
R 8 0000
R 9 0000
P 000E
T signs
I 00 A101 A2FE 0312 C601
I 04 A401 C401 A501 1612
I 08 C401 A701 C601 A801
I 0C CA01 A901 F000 E000
R 3 FFFF
R 4 0000
R 5 0001
R 6 0003
R 7 0000
R 8 0001
R 9 0001
P 000F
T overflow
I 00 A240 0222 0222 0222
I 04 0222 0222 0222 0222
I 08 0222 0322 C801 A401
I 0C 0532 C801 A601 F000
R 2 4000
R 3 8000
R 4 0000
R 5 C000
R 6 0001
P 0010
T loop
I 00 A103 A2FF 0331 0112
I 04 C1FD D400 0543 F000
R 1 0000
R 3 0006
R 4 0006
R 5 000C
P 0008

// ==== build.f ====
+incdir+.
cpuPkg.sv
hazardIf.sv
stageReg.sv
cpuFetch.sv
cpuDecode.sv
cpuExecute.sv
cpuMemory.sv
cpuHazard.sv
cpu.sv
cpu_tb.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = cpu_tb
RTL_TOP    = cpu
FILELIST   = build.f
LOG        = sim.log
PASS_TEXT  = Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

  localparam int ClkPeriod    = 20;
  localparam int RstCycles    = 16;    // Program load fits inside reset
  localparam int HaltTimeout  = 2000;  // Cycles from reset release to hlt
  localparam int WordsPerLine = 4;     // Instruction words on one I line
  localparam int LineFeed     = 10;
  localparam int EndOfFile    = -1;

  logic           clk;
  logic           rstN;
  logic           imemWe;
  cpuPkg::wordT   imemAddr;
  cpuPkg::wordT   imemData;
  cpuPkg::regIdxT dbgRegAddr;
  cpuPkg::wordT   dbgRegData;
  cpuPkg::wordT   pc;
  logic           hlt;

  // Current test as read from the trace
  logic [8*24-1:0] testName;
  cpuPkg::wordT    progAddr [$];
  cpuPkg::wordT    progWord [$];
  cpuPkg::regIdxT  expIdx [$];      // Registers to check
  cpuPkg::wordT    expVal [$];

  int testCount;
  int checkCount;
  int errorCount;

  cpu dut (
    .clk(clk), .rstN(rstN),
    .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
    .dbgRegAddr(dbgRegAddr), .dbgRegData(dbgRegData),
    .pc(pc), .hlt(hlt)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  //////////////////////
  // Reporting
  //////////////////////
  task automatic reportError(string what);
    errorCount++;
    $display("ERROR at %0d ns: %0s", $time, what);
  endtask

  task automatic checkWord(string sigName, cpuPkg::wordT got, cpuPkg::wordT expected);
    checkCount++;
    assert (got === expected) else begin
      errorCount++;
      $display("FAIL at %0d ns: %0s got %h expected %h", $time, sigName, got, expected);
    end
  endtask

  //////////////////////
  // One program
  //////////////////////
  task automatic runTest(cpuPkg::wordT haltPc);
    int    i;
    int    cycles;
    int    errorsBefore;
    string sigName;
    errorsBefore = errorCount;
    testCount++;
    assert (progWord.size() <= RstCycles) else
      reportError($sformatf("%0s: program longer than the reset window", testName));
    @(negedge clk);
    rstN = 1'b0;
    for (i = 0; i < RstCycles; i++) begin
      imemWe = (i < progWord.size());       // One word per cycle while in reset
      if (imemWe) begin
        imemAddr = progAddr[i];
        imemData = progWord[i];
      end
      @(negedge clk);
    end
    imemWe = 1'b0;
    rstN   = 1'b1;

    cycles = 0;                             // Latency varies so hlt marks the end
    while (!hlt && cycles < HaltTimeout) begin
      @(negedge clk);
      cycles++;
    end
    checkCount++;
    assert (hlt) else
      reportError($sformatf("%0s: hlt did not rise within %0d cycles", testName, HaltTimeout));

    if (hlt) begin
      for (i = 0; i < expIdx.size(); i++) begin
        dbgRegAddr = expIdx[i];             // Combinational read sampled at the next falling edge
        @(negedge clk);
        sigName = $sformatf("dbgRegData r%0d", expIdx[i]);
        checkWord(sigName, dbgRegData, expVal[i]);
      end
      checkCount++;
      assert (hlt) else
        reportError($sformatf("%0s: hlt fell after the halt", testName));
      checkWord("pc", pc, haltPc);          // Held at HLT address plus one
    end

    $display("test %0s: %0s, %0d cycles to hlt, %0d errors", testName,
             (errorCount == errorsBefore) ? "pass" : "fail", cycles,
             errorCount - errorsBefore);
    progAddr.delete();
    progWord.delete();
    expIdx.delete();
    expVal.delete();
  endtask

  //////////////////////
  // Trace reader and run
  //////////////////////
  initial begin
    int             fd;
    int             ch;
    int             n;
    logic [7:0]     tag;
    logic           parseOk;
    cpuPkg::wordT   addr;
    cpuPkg::wordT   words [WordsPerLine];
    cpuPkg::regIdxT idx;
    cpuPkg::wordT   value;

    rstN       = 1'b0;
    imemWe     = 1'b0;
    imemAddr   = '0;
    imemData   = '0;
    dbgRegAddr = '0;
    testCount  = 0;
    checkCount = 0;
    errorCount = 0;
    parseOk    = 1'b1;

    fd = $fopen("cpu_trace.txt", "r");
    assert (fd != 0) else reportError("cannot open cpu_trace.txt");
    while (fd != 0 && parseOk && $fscanf(fd, " %c", tag) == 1) begin
      case (tag)
        "#": begin                          // Skip the rest of a comment line
          ch = $fgetc(fd);
          while (ch != LineFeed && ch != EndOfFile) begin
            ch = $fgetc(fd);
          end
        end
        "T": parseOk = ($fscanf(fd, "%s", testName) == 1);
        "I": begin                          // Address then four consecutive words
          parseOk = ($fscanf(fd, "%h %h %h %h %h", addr,
                             words[0], words[1], words[2], words[3]) == 5);
          for (n = 0; n < WordsPerLine; n++) begin
            progAddr.push_back(addr + cpuPkg::wordT'(n));
            progWord.push_back(words[n]);
          end
        end
        "R": begin
          parseOk = ($fscanf(fd, "%h %h", idx, value) == 2);
          expIdx.push_back(idx);
          expVal.push_back(value);
        end
        "P": begin                          // Halt pc closes the test
          parseOk = ($fscanf(fd, "%h", value) == 1);
          if (parseOk) begin
            runTest(value);
          end
        end
        default: parseOk = 1'b0;
      endcase
      assert (parseOk) else
        reportError($sformatf("malformed trace entry with tag %c", tag));
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    assert (testCount > 0) else reportError("no tests found in cpu_trace.txt");

    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu (
  input  logic           clk,
  input  logic           rstN,
  input  logic           imemWe,       // Program load
  input  cpuPkg::wordT   imemAddr,
  input  cpuPkg::wordT   imemData,
  input  cpuPkg::regIdxT dbgRegAddr,   // Debug register read
  output cpuPkg::wordT   dbgRegData,
  output cpuPkg::wordT   pc,
  output logic           hlt
);

  cpuPkg::ifIdT  ifD, ifQ;
  cpuPkg::idExT  idD, idQ;
  cpuPkg::exMemT exD, exQ;
  cpuPkg::memWbT memD, memQ;
  cpuPkg::flagsT flags;
  logic          branchTaken;
  cpuPkg::wordT  branchTarget;
  logic          halting;

  hazardIf haz ();

  // In-flight producers for the hazard unit
  assign haz.exRd        = idQ.rd;
  assign haz.exRegWrite  = idQ.valid && idQ.regWrite;
  assign haz.exSetFlag   = idQ.valid && (idQ.setZ || idQ.setNv);
  assign haz.memRd       = exQ.rd;
  assign haz.memRegWrite = exQ.valid && exQ.regWrite;

  cpuHazard iHazard (.haz(haz));

  //////////////////////
  // Fetch
  //////////////////////
  cpuFetch iFetch (
    .clk(clk), .rstN(rstN),
    .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
    .haz(haz),
    .branchTaken(branchTaken), .branchTarget(branchTarget), .halting(halting),
    .pc(pc), .ifOut(ifD)
  );

  stageReg #(.payloadT(cpuPkg::ifIdT)) iIfId (
    .clk(clk), .rstN(rstN), .stall(haz.stall), .flush(haz.flushIfId),
    .bubbleOnStall(1'b0), .d(ifD), .q(ifQ)                  // Holds under stall
  );

  //////////////////////
  // Decode
  //////////////////////
  cpuDecode iDecode (
    .clk(clk), .rstN(rstN),
    .ifIn(ifQ), .wbIn(memQ), .flags(flags),
    .dbgRegAddr(dbgRegAddr), .dbgRegData(dbgRegData),
    .haz(haz), .idOut(idD),
    .branchTaken(branchTaken), .branchTarget(branchTarget),
    .halting(halting), .hlt(hlt)
  );

  stageReg #(.payloadT(cpuPkg::idExT)) iIdEx (
    .clk(clk), .rstN(rstN), .stall(haz.stall), .flush(1'b0),
    .bubbleOnStall(1'b1), .d(idD), .q(idQ)                  // Bubble under stall
  );

  //////////////////////
  // Execute and memory
  //////////////////////
  cpuExecute iExecute (
    .clk(clk), .rstN(rstN), .exIn(idQ), .exOut(exD), .flags(flags)
  );

  stageReg #(.payloadT(cpuPkg::exMemT)) iExMem (
    .clk(clk), .rstN(rstN), .stall(1'b0), .flush(1'b0),
    .bubbleOnStall(1'b0), .d(exD), .q(exQ)
  );

  cpuMemory iMemory (.clk(clk), .memIn(exQ), .memOut(memD));

  stageReg #(.payloadT(cpuPkg::memWbT)) iMemWb (
    .clk(clk), .rstN(rstN), .stall(1'b0), .flush(1'b0),
    .bubbleOnStall(1'b0), .d(memD), .q(memQ)                // Back to decode for write-back
  );

endmodule

`default_nettype wire

// ==== cpuHazard.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuHazard (
  hazardIf.hazard haz
);

  logic rawEx;
  logic rawMem;
  logic flagHaz;

  // Source read that collides with a pending write
  function automatic logic hits(cpuPkg::regIdxT src, logic used,
                                cpuPkg::regIdxT dst, logic we);
    return used && we && (dst != '0) && (dst == src);
  endfunction

  //////////////////////
  // Stall detection
  //////////////////////
  assign rawEx   = hits(haz.src1, haz.useSrc1, haz.exRd, haz.exRegWrite)
                || hits(haz.src2, haz.useSrc2, haz.exRd, haz.exRegWrite);    // Two cycles
  assign rawMem  = hits(haz.src1, haz.useSrc1, haz.memRd, haz.memRegWrite)
                || hits(haz.src2, haz.useSrc2, haz.memRd, haz.memRegWrite);  // One cycle
  assign flagHaz = haz.usesFlags && haz.exSetFlag;  // Flags land at end of EX

  assign haz.stall     = rawEx || rawMem || flagHaz;
  assign haz.flushIfId = haz.branchTaken && !haz.stall;  // Kill the wrong-path fetch

endmodule

`default_nettype wire

// ==== cpuMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module cpuMemory (
  input  logic          clk,
  input  cpuPkg::exMemT memIn,
  output cpuPkg::memWbT memOut
);

  localparam int DmemAw = $clog2(`CPU_DMEM_DEPTH);

  cpuPkg::wordT        dmem [`CPU_DMEM_DEPTH];
  logic [DmemAw-1:0]   addr;

  assign addr = memIn.aluResult[DmemAw-1:0];    // Word address, upper bits ignored

  always_ff @(posedge clk) begin
    if (memIn.valid && memIn.memWrite) begin
      dmem[addr] <= memIn.storeData;
    end
  end

  always_comb begin
    memOut.valid    = memIn.valid;
    memOut.result   = memIn.memRead ? dmem[addr] : memIn.aluResult;  // LW takes memory word
    memOut.rd       = memIn.rd;
    memOut.regWrite = memIn.regWrite;
    memOut.isPcs    = memIn.isPcs;
    memOut.isHlt    = memIn.isHlt;
    memOut.nextPc   = memIn.nextPc;
  end

endmodule

`default_nettype wire

// ==== cpuExecute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module cpuExecute (
  input  logic          clk,
  input  logic          rstN,
  input  cpuPkg::idExT  exIn,
  output cpuPkg::exMemT exOut,
  output cpuPkg::flagsT flags       // Read by branch in decode
);

  localparam int Msb = `CPU_WIDTH - 1;

  cpuPkg::wordT result;
  logic         vNext;

  //////////////////////
  // ALU
  //////////////////////
  always_comb begin
    vNext = 1'b0;
    case (exIn.opcode)
      cpuPkg::opAdd: begin
        result = exIn.opA + exIn.opB;
        vNext  = (exIn.opA[Msb] == exIn.opB[Msb]) && (result[Msb] != exIn.opA[Msb]);
      end
      cpuPkg::opSub: begin
        result = exIn.opA - exIn.opB;
        vNext  = (exIn.opA[Msb] != exIn.opB[Msb]) && (result[Msb] != exIn.opA[Msb]);
      end
      cpuPkg::opXor: result = exIn.opA ^ exIn.opB;
      cpuPkg::opLlb: result = exIn.opB;         // Immediate pass
      default:       result = exIn.opA + exIn.opB;  // LW/SW address
    endcase
  end

  // Only valid setters touch the flags
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else if (exIn.valid) begin
      if (exIn.setZ) flags.z <= (result == '0);
      if (exIn.setNv) begin
        flags.n <= result[Msb];
        flags.v <= vNext;
      end
    end
  end

  always_comb begin
    exOut.valid     = exIn.valid;
    exOut.aluResult = result;
    exOut.storeData = exIn.storeData;
    exOut.memRead   = exIn.memRead;
    exOut.memWrite  = exIn.memWrite;
    exOut.regWrite  = exIn.regWrite;
    exOut.rd        = exIn.rd;
    exOut.isPcs     = exIn.isPcs;
    exOut.isHlt     = exIn.isHlt;
    exOut.nextPc    = exIn.nextPc;
  end

endmodule

`default_nettype wire

// ==== cpuDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module cpuDecode (
  input  logic           clk,
  input  logic           rstN,
  input  cpuPkg::ifIdT   ifIn,
  input  cpuPkg::memWbT  wbIn,          // Write-back slot
  input  cpuPkg::flagsT  flags,
  input  cpuPkg::regIdxT dbgRegAddr,
  output cpuPkg::wordT   dbgRegData,
  hazardIf.decode        haz,
  output cpuPkg::idExT   idOut,
  output logic           branchTaken,
  output cpuPkg::wordT   branchTarget,
  output logic           halting,       // Fetch stops
  output logic           hlt
);

  cpuPkg::wordT   regs [`CPU_NUM_REGS];
  cpuPkg::opcodeE opcode;
  cpuPkg::condE   cond;
  cpuPkg::regIdxT rd, rs, rt;
  cpuPkg::wordT   rsData, rtData, rdData;
  cpuPkg::wordT   pcPlus1;
  cpuPkg::wordT   wbData;
  logic           wbWe;
  logic           isBranch;
  logic           condMet;
  logic           haltReg;
  logic           hltReg;

  assign opcode  = cpuPkg::opcodeE'(ifIn.instr[15:12]);
  assign rd      = ifIn.instr[11:8];
  assign rs      = ifIn.instr[7:4];
  assign rt      = ifIn.instr[3:0];
  assign cond    = cpuPkg::condE'(ifIn.instr[11:9]);
  assign pcPlus1 = ifIn.pc + cpuPkg::wordT'(1);

  //////////////////////
  // Register file
  //////////////////////
  assign wbWe   = wbIn.valid && wbIn.regWrite;
  assign wbData = wbIn.isPcs ? wbIn.nextPc : wbIn.result;  // PCS writes pc+1

  function automatic cpuPkg::wordT readReg(cpuPkg::regIdxT addr);
    if (addr == '0) begin
      return '0;                                // r0 hardwired
    end
    if (wbWe && wbIn.rd == addr) begin
      return wbData;                            // Same-cycle pass-through
    end
    return regs[addr];
  endfunction

  always_comb begin
    rsData     = readReg(rs);
    rtData     = readReg(rt);
    rdData     = readReg(rd);                   // SW store source
    dbgRegData = readReg(dbgRegAddr);
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wbWe && wbIn.rd != '0) begin
      regs[wbIn.rd] <= wbData;
    end
  end

  //////////////////////
  // Control decode
  //////////////////////
  always_comb begin
    idOut         = '0;
    haz.src1      = rs;
    haz.src2      = rt;
    haz.useSrc1   = 1'b0;
    haz.useSrc2   = 1'b0;
    haz.usesFlags = 1'b0;
    isBranch      = 1'b0;
    idOut.valid   = ifIn.valid;
    idOut.opcode  = opcode;
    idOut.rd      = rd;
    idOut.opA     = rsData;
    idOut.nextPc  = pcPlus1;
    case (opcode)
      cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opXor: begin
        haz.useSrc1    = 1'b1;
        haz.useSrc2    = 1'b1;
        idOut.opB      = rtData;
        idOut.regWrite = 1'b1;
        idOut.setZ     = 1'b1;
        idOut.setNv    = (opcode != cpuPkg::opXor);  // XOR touches Z only
      end
      cpuPkg::opLw: begin
        haz.useSrc1    = 1'b1;
        idOut.opB      = cpuPkg::wordT'($signed(ifIn.instr[3:0]));
        idOut.regWrite = 1'b1;
        idOut.memRead  = 1'b1;
      end
      cpuPkg::opSw: begin
        haz.useSrc1     = 1'b1;
        haz.src2        = rd;                   // Store data comes from rd
        haz.useSrc2     = 1'b1;
        idOut.opB       = cpuPkg::wordT'($signed(ifIn.instr[3:0]));
        idOut.storeData = rdData;
        idOut.memWrite  = 1'b1;
      end
      cpuPkg::opLlb: begin
        idOut.opB      = cpuPkg::wordT'($signed(ifIn.instr[7:0]));
        idOut.regWrite = 1'b1;
      end
      cpuPkg::opB: begin
        haz.usesFlags = 1'b1;
        isBranch      = 1'b1;
      end
      cpuPkg::opPcs: begin
        idOut.regWrite = 1'b1;
        idOut.isPcs    = 1'b1;
      end
      cpuPkg::opHlt: idOut.isHlt = 1'b1;
      default: ;                                // NOP and undefined opcodes
    endcase
    if (!ifIn.valid) begin                      // Bubble carries no controls
      idOut         = '0;
      haz.useSrc1   = 1'b0;
      haz.useSrc2   = 1'b0;
      haz.usesFlags = 1'b0;
      isBranch      = 1'b0;
    end
  end

  //////////////////////
  // Branch resolution
  //////////////////////
  always_comb begin
    case (cond)
      cpuPkg::condNe:     condMet = !flags.z;
      cpuPkg::condEq:     condMet = flags.z;
      cpuPkg::condGt:     condMet = !flags.z && !flags.n;
      cpuPkg::condLt:     condMet = flags.n;
      cpuPkg::condOvf:    condMet = flags.v;
      cpuPkg::condAlways: condMet = 1'b1;
      default:            condMet = 1'b0;       // Reserved codes never taken
    endcase
  end

  assign branchTaken     = isBranch && condMet;
  assign branchTarget    = pcPlus1 + cpuPkg::wordT'($signed(ifIn.instr[8:0]));
  assign haz.branchTaken = branchTaken;

  //////////////////////
  // Halt
  //////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      haltReg <= 1'b0;
      hltReg  <= 1'b0;
    end else begin
      if (idOut.isHlt) haltReg <= 1'b1;         // Sticky until reset
      if (wbIn.valid && wbIn.isHlt) hltReg <= 1'b1;
    end
  end

  assign halting = haltReg || idOut.isHlt;      // Pc freezes at HLT+1
  assign hlt     = hltReg || (wbIn.valid && wbIn.isHlt);

endmodule

`default_nettype wire

// ==== cpuFetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module cpuFetch (
  input  logic          clk,
  input  logic          rstN,
  input  logic          imemWe,        // Program load port
  input  cpuPkg::wordT  imemAddr,
  input  cpuPkg::wordT  imemData,
  hazardIf.stage        haz,
  input  logic          branchTaken,   // Resolved in decode
  input  cpuPkg::wordT  branchTarget,
  input  logic          halting,
  output cpuPkg::wordT  pc,
  output cpuPkg::ifIdT  ifOut
);

  localparam int ImemAw = $clog2(`CPU_IMEM_DEPTH);

  cpuPkg::wordT imem [`CPU_IMEM_DEPTH];
  cpuPkg::wordT pcNext;

  always_ff @(posedge clk) begin
    if (imemWe) begin
      imem[imemAddr[ImemAw-1:0]] <= imemData;
    end
  end

  //////////////////////
  // Next pc
  //////////////////////
  always_comb begin
    if (haz.stall || halting) begin
      pcNext = pc;                              // Hold, decode is busy or done
    end else if (branchTaken) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pc + cpuPkg::wordT'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

  // Nothing past HLT enters the pipe
  always_comb begin
    ifOut.valid = !halting;
    ifOut.pc    = pc;
    ifOut.instr = imem[pc[ImemAw-1:0]];         // Combinational read
  end

endmodule

`default_nettype wire

// ==== stageReg.sv ====
`timescale 1ns/1ps
`default_nettype none

module stageReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    stall,
  input  logic    flush,
  input  logic    bubbleOnStall,  // Per instance, stall bubbles instead of holding
  input  payloadT d,
  output payloadT q
);

  // All-zero payload is a bubble since valid clears
  always_ff @(posedge clk) begin
    if (!rstN || flush) begin
      q <= '0;
    end else if (stall) begin
      if (bubbleOnStall) begin
        q <= '0;                  // Let the stalled slot drain downstream
      end
    end else begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// ==== hazardIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface hazardIf;

  cpuPkg::regIdxT src1;         // Decode sources
  cpuPkg::regIdxT src2;
  logic           useSrc1;
  logic           useSrc2;
  logic           usesFlags;    // Branch in decode
  logic           branchTaken;

  cpuPkg::regIdxT exRd;         // Producer in ID/EX
  logic           exRegWrite;
  logic           exSetFlag;
  cpuPkg::regIdxT memRd;        // Producer in EX/MEM
  logic           memRegWrite;

  logic           stall;
  logic           flushIfId;

  modport decode (output src1, src2, useSrc1, useSrc2, usesFlags, branchTaken);
  modport hazard (input src1, src2, useSrc1, useSrc2, usesFlags, branchTaken,
                  input exRd, exRegWrite, exSetFlag, memRd, memRegWrite,
                  output stall, flushIfId);
  modport stage (input stall, flushIfId);

endinterface

`default_nettype wire

// ==== cpuPkg.sv ====
`default_nettype none

`include "cpu_macros.svh"

package cpuPkg;

  typedef logic [`CPU_WIDTH-1:0] wordT;               // Data word or address
  typedef logic [$clog2(`CPU_NUM_REGS)-1:0] regIdxT;  // Register index

  typedef enum logic [3:0] {
    opAdd = 4'h0,
    opSub = 4'h1,
    opXor = 4'h2,
    opLw  = 4'h8,
    opSw  = 4'h9,
    opLlb = 4'hA,
    opB   = 4'hC,
    opPcs = 4'hD,
    opNop = 4'hE,
    opHlt = 4'hF
  } opcodeE;

  typedef enum logic [2:0] {
    condNe     = 3'd0,  // Z clear
    condEq     = 3'd1,  // Z set
    condGt     = 3'd2,  // Z and N clear
    condLt     = 3'd3,  // N set
    condOvf    = 3'd4,  // V set
    condAlways = 3'd7
  } condE;

  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } flagsT;

  //////////////////////
  // Pipeline payloads
  //////////////////////
  typedef struct packed {
    logic valid;
    wordT pc;       // Address of this instruction
    wordT instr;
  } ifIdT;

  typedef struct packed {
    logic   valid;
    opcodeE opcode;     // Selects the ALU function
    regIdxT rd;
    wordT   opA;
    wordT   opB;        // Register or sign-extended immediate
    wordT   storeData;  // SW source
    logic   regWrite;
    logic   memRead;
    logic   memWrite;
    logic   setZ;
    logic   setNv;
    logic   isPcs;
    logic   isHlt;
    wordT   nextPc;     // pc+1, written back by PCS
  } idExT;

  typedef struct packed {
    logic   valid;
    wordT   aluResult;  // Also the data memory address
    wordT   storeData;
    logic   memRead;
    logic   memWrite;
    logic   regWrite;
    regIdxT rd;
    logic   isPcs;
    logic   isHlt;
    wordT   nextPc;
  } exMemT;

  typedef struct packed {
    logic   valid;
    wordT   result;     // ALU or memory word
    regIdxT rd;
    logic   regWrite;
    logic   isPcs;
    logic   isHlt;
    wordT   nextPc;
  } memWbT;

endpackage

`default_nettype wire

// ==== cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

//////////////////////
// Core sizing
//////////////////////
`define CPU_WIDTH      16   // Data and address width
`define CPU_NUM_REGS   16   // Architectural registers, r0 reads zero

//////////////////////
// Memory depths in words
//////////////////////
`define CPU_IMEM_DEPTH 256  // Instruction memory
`define CPU_DMEM_DEPTH 256  // Data memory

`endif
